//--- source/rv32i_types_pkg.sv
`default_nettype none
////////////////////
// instruction-level types for the load/store stage
// memory op codes, rv32i width codes and the in/out records
////////////////////

package rv32i_types_pkg;

    // record field widths
    localparam int OP_W    = 2;
    localparam int WIDTH_W = 3;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int RD_W    = 5;
    localparam int TAG_W   = 8;

    typedef enum logic [OP_W-1:0] {
        op_none  = 2'b00, // alu result passes through
        op_load  = 2'b01,
        op_store = 2'b10
    } mem_op_e;

    // same encoding as funct3 of rv32i loads/stores
    typedef enum logic [WIDTH_W-1:0] {
        width_byte   = 3'b000,
        width_half   = 3'b001,
        width_word   = 3'b010,
        width_byte_u = 3'b100,
        width_half_u = 3'b101
    } width_e;

    // record from execute, 82 bits
    typedef struct packed {
        mem_op_e             op;
        width_e              width;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;  // store data or alu result
        logic [RD_W-1:0]     rd;
        logic [TAG_W-1:0]    tag;   // order tag, only carried along
    } in_rec_t;

    // record toward writeback, 46 bits
    typedef struct packed {
        logic [RD_W-1:0]     rd;
        logic [DATA_W-1:0]   result;
        logic [TAG_W-1:0]    tag;
        logic                is_load;
    } wb_rec_t;

endpackage

`default_nettype wire

//--- source/lsu_flow_pkg.sv
`default_nettype none
////////////////////
// flow control and sizing constants of the load/store stage
////////////////////

package lsu_flow_pkg;

    localparam int IN_DEPTH   = 4;   // input queue depth = upstream credits at start
    localparam int WB_DEPTH   = 4;   // output queue depth
    localparam int WB_CREDITS = 2;   // consumer buffer size
    localparam int MEM_WORDS  = 256; // data memory words
    localparam int LAT_BASE   = 1;   // min memory latency in cycles

    // derived widths
    localparam int WB_CNT_W = $clog2(WB_DEPTH) + 1;
    localparam int CRED_W   = $clog2(WB_CREDITS + 1);
    localparam int MEM_AW   = $clog2(MEM_WORDS);
    localparam int LAT_W    = 3; // holds LAT_BASE - 1 + 3

    // typed forms for direct compare/load
    localparam logic [WB_CNT_W-1:0] WB_FULL      = WB_CNT_W'(WB_DEPTH);
    localparam logic [CRED_W-1:0]   WB_CRED_INIT = CRED_W'(WB_CREDITS);
    localparam logic [LAT_W-1:0]    LAT_OFFSET   = LAT_W'(LAT_BASE - 1);

endpackage

`default_nettype wire

//--- source/lsu_queue.sv
`default_nettype none
////////////////////
// circular FIFO with a generic payload
// a registered credit pulse follows every pop
////////////////////

module lsu_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  wire logic                  clk,
    input  wire logic                  mem_resp_d,  // async reset, active high
    input  wire logic                  push,
    input  wire payload_t              push_data,
    input  wire logic                  pop,
    output logic                       head_valid,
    output payload_t                   head_data,
    output logic [$clog2(depth):0]     count,
    output logic                       credit
);

    typedef logic [$clog2(depth)-1:0] ptr_t;
    typedef logic [$clog2(depth):0]   cnt_t;

    payload_t slots [depth];   // entry storage

    ptr_t rd_ptr;
    ptr_t wr_ptr;
    logic do_push;
    logic do_pop;

    assign head_valid = (count != '0);
    assign head_data  = slots[rd_ptr];

    assign do_pop  = pop && head_valid;                      // pop on empty is dropped
    assign do_push = push && ((count != cnt_t'(depth)) || do_pop); // full unless popping

    // pointers and occupancy
    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // one credit per freed slot a cycle after the pop
    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            credit <= 1'b0;
        end else begin
            credit <= do_pop;
        end
    end

    // payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`default_nettype none
////////////////////
// memory stage controller
// issues/holds dmem requests, lines up store lanes, extends loads
////////////////////

module mem_stage (
    input  wire logic                      clk,
    input  wire logic                      mem_resp_d,  // async reset
    input  wire logic                      q_valid,     // input queue head present
    input  wire rv32i_types_pkg::in_rec_t  q_rec,
    output logic                           deq,
    output logic                           mem_r_d,
    output logic                           mem_w_d,
    output logic [31:0]                    mem_addr,
    output logic [31:0]                    mem_wdata,
    output logic [3:0]                     mem_byte_en,
    input  wire logic                      dmem_resp,
    input  wire logic [31:0]               dmem_rdata,
    input  wire logic                      wb_space,
    output logic                           wb_push,
    output rv32i_types_pkg::wb_rec_t       wb_rec
);

    typedef enum logic [1:0] {
        st_idle,
        st_request, // request held until dmem_resp
        st_done     // finished record waits for wb_space
    } state_e;

    state_e                    state;
    rv32i_types_pkg::in_rec_t  cur;      // latched head record
    logic [31:0]               res_q;    // result to write back
    logic [31:0]               shifted;  // load word moved down to lane 0
    logic [31:0]               load_val;
    logic [1:0]                off;
    logic                      is_mem;
    logic                      is_load;

    assign off     = cur.addr[1:0];
    assign is_load = (cur.op == rv32i_types_pkg::op_load);
    assign is_mem  = (q_rec.op == rv32i_types_pkg::op_load) ||
                     (q_rec.op == rv32i_types_pkg::op_store);

    assign deq     = (state == st_idle) && q_valid;  // take head only when free
    assign wb_push = (state == st_done) && wb_space;

    // request lines, held steady from the latched record
    assign mem_r_d  = (state == st_request) && is_load;
    assign mem_w_d  = (state == st_request) && (cur.op == rv32i_types_pkg::op_store);
    assign mem_addr = cur.addr;

    // store lanes: replicate data, enable the addressed bytes
    always_comb begin
        case (cur.width)
            rv32i_types_pkg::width_byte: begin
                mem_wdata   = {4{cur.data[7:0]}};
                mem_byte_en = 4'b0001 << off;
            end
            rv32i_types_pkg::width_half: begin
                mem_wdata   = {2{cur.data[15:0]}};
                mem_byte_en = 4'b0011 << {off[1], 1'b0}; // lower or upper half
            end
            default: begin
                mem_wdata   = cur.data;
                mem_byte_en = 4'b1111;
            end
        endcase
        if (!mem_w_d) begin
            mem_byte_en = 4'b0000;  // no enables outside a write
        end
    end

    // load alignment and extension
    assign shifted = dmem_rdata >> {off, 3'b000};

    always_comb begin
        case (cur.width)
            rv32i_types_pkg::width_byte:   load_val = {{24{shifted[7]}}, shifted[7:0]};
            rv32i_types_pkg::width_byte_u: load_val = {24'h000000, shifted[7:0]};
            rv32i_types_pkg::width_half:   load_val = {{16{shifted[15]}}, shifted[15:0]};
            rv32i_types_pkg::width_half_u: load_val = {16'h0000, shifted[15:0]};
            default:                       load_val = dmem_rdata; // full word
        endcase
    end

    // control FSM
    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (q_valid) state <= is_mem ? st_request : st_done;
                st_request: if (dmem_resp) state <= st_done; // request drops next cycle
                st_done: if (wb_space) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // record and result capture
    always_ff @(posedge clk) begin
        if (deq) begin
            cur   <= q_rec;
            res_q <= q_rec.data;          // alu result for non-memory ops
        end else if ((state == st_request) && dmem_resp && is_load) begin
            res_q <= load_val;
        end
    end

    always_comb begin
        wb_rec.rd      = cur.rd;
        wb_rec.result  = res_q;
        wb_rec.tag     = cur.tag;
        wb_rec.is_load = is_load;
    end

endmodule

`default_nettype wire

//--- source/dmem_array.sv
`default_nettype none
////////////////////
// word data memory, byte-enabled writes,
// response latency set by address bits [3:2]
////////////////////

module dmem_array (
    input  wire logic         clk,
    input  wire logic         mem_resp_d,  // async reset
    input  wire logic         mem_r_d,
    input  wire logic         mem_w_d,
    input  wire logic [31:0]  mem_addr,
    input  wire logic [31:0]  mem_wdata,
    input  wire logic [3:0]   mem_byte_en,
    output logic              dmem_resp,   // one cycle per access
    output logic [31:0]       dmem_rdata
);

    logic [31:0] mem [lsu_flow_pkg::MEM_WORDS];

    logic [lsu_flow_pkg::MEM_AW-1:0] idx;
    logic [lsu_flow_pkg::LAT_W-1:0]  cnt;        // cycles still to wait
    logic [lsu_flow_pkg::LAT_W-1:0]  remaining;
    logic                            busy;       // countdown running
    logic                            active;
    logic                            fire;       // access happens this edge

    assign idx = mem_addr[lsu_flow_pkg::MEM_AW+1:2];

    // request is still high in the resp cycle, don't restart on it
    assign active = (mem_r_d || mem_w_d) && !dmem_resp;

    // new request loads its latency, running one keeps counting
    assign remaining = busy ? cnt
                            : lsu_flow_pkg::LAT_OFFSET + lsu_flow_pkg::LAT_W'(mem_addr[3:2]);

    assign fire = active && (remaining == '0);

    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            busy      <= 1'b0;
            cnt       <= '0;
            dmem_resp <= 1'b0;
        end else begin
            dmem_resp <= fire;
            if (fire) begin
                busy <= 1'b0;
            end else if (active) begin
                busy <= 1'b1;
                cnt  <= remaining - 1'b1;
            end
        end
    end

    // storage, cleared at reset
    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            for (int i = 0; i < lsu_flow_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (fire && mem_w_d) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_byte_en[b]) begin
                    mem[idx][b*8 +: 8] <= mem_wdata[b*8 +: 8]; // only enabled lanes
                end
            end
        end
    end

    // read data lines up with dmem_resp
    always_ff @(posedge clk) begin
        if (fire && mem_r_d) begin
            dmem_rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- source/wb_port.sv
`default_nettype none
////////////////////
// writeback side: output FIFO
// plus credit counter toward the consumer
////////////////////

module wb_port (
    input  wire logic                      clk,
    input  wire logic                      mem_resp_d,  // async reset
    input  wire logic                      wb_push,
    input  wire rv32i_types_pkg::wb_rec_t  wb_rec,
    output logic                           wb_space,
    input  wire logic                      wb_credit,   // consumer freed one entry
    output logic                           wb_valid,
    output rv32i_types_pkg::wb_rec_t       wb_out
);

    logic [lsu_flow_pkg::WB_CNT_W-1:0] wb_count;
    logic [lsu_flow_pkg::CRED_W-1:0]   credits;   // free consumer slots
    logic                              head_valid;

    lsu_queue #(
        .payload_t (rv32i_types_pkg::wb_rec_t),
        .depth     (lsu_flow_pkg::WB_DEPTH)
    ) wb_q (
        .clk        (clk),
        .mem_resp_d (mem_resp_d),
        .push       (wb_push),
        .push_data  (wb_rec),
        .pop        (wb_valid),    // each send frees a slot
        .head_valid (head_valid),
        .head_data  (wb_out),
        .count      (wb_count),
        .credit     ()
    );

    assign wb_space = (wb_count < lsu_flow_pkg::WB_FULL);
    assign wb_valid = head_valid && (credits != '0); // send only with a credit

    // send and credit return may land in the same cycle
    always_ff @(posedge clk or posedge mem_resp_d) begin
        if (mem_resp_d) begin
            credits <= lsu_flow_pkg::WB_CRED_INIT;
        end else begin
            case ({wb_valid, wb_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/lsu_top.sv
`default_nettype none
////////////////////
// load/store subsystem top
////////////////////

module lsu_top (
    input  wire logic                      clk,
    input  wire logic                      mem_resp_d,  // async reset, active high
    input  wire logic                      in_valid,
    input  wire rv32i_types_pkg::in_rec_t  in_rec,
    output logic                           in_credit,   // one credit back per pop
    input  wire logic                      wb_credit,
    output logic                           wb_valid,
    output rv32i_types_pkg::wb_rec_t       wb_out
);

    rv32i_types_pkg::in_rec_t  q_rec;
    rv32i_types_pkg::wb_rec_t  wb_rec;
    logic                      q_valid;
    logic                      deq;
    logic                      wb_push;
    logic                      wb_space;
    logic                      mem_r_d;
    logic                      mem_w_d;
    logic [31:0]               mem_addr;
    logic [31:0]               mem_wdata;
    logic [3:0]                mem_byte_en;
    logic                      dmem_resp;
    logic [31:0]               dmem_rdata;

    // input queue, sized to the upstream credits
    lsu_queue #(
        .payload_t (rv32i_types_pkg::in_rec_t),
        .depth     (lsu_flow_pkg::IN_DEPTH)
    ) in_q (
        .clk        (clk),
        .mem_resp_d (mem_resp_d),
        .push       (in_valid),
        .push_data  (in_rec),
        .pop        (deq),
        .head_valid (q_valid),
        .head_data  (q_rec),
        .count      (),
        .credit     (in_credit)
    );

    mem_stage mem_stage_i (
        .clk         (clk),
        .mem_resp_d  (mem_resp_d),
        .q_valid     (q_valid),
        .q_rec       (q_rec),
        .deq         (deq),
        .mem_r_d     (mem_r_d),
        .mem_w_d     (mem_w_d),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .dmem_resp   (dmem_resp),
        .dmem_rdata  (dmem_rdata),
        .wb_space    (wb_space),
        .wb_push     (wb_push),
        .wb_rec      (wb_rec)
    );

    dmem_array dmem_i (
        .clk         (clk),
        .mem_resp_d  (mem_resp_d),
        .mem_r_d     (mem_r_d),
        .mem_w_d     (mem_w_d),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .dmem_resp   (dmem_resp),
        .dmem_rdata  (dmem_rdata)
    );

    wb_port wb_port_i (
        .clk        (clk),
        .mem_resp_d (mem_resp_d),
        .wb_push    (wb_push),
        .wb_rec     (wb_rec),
        .wb_space   (wb_space),
        .wb_credit  (wb_credit),
        .wb_valid   (wb_valid),
        .wb_out     (wb_out)
    );

endmodule

`default_nettype wire

//--- verification/lsu_tb.sv
`default_nettype none
////////////////////
// testbench for the load/store subsystem
// file-driven records, credit models on both sides, writeback checks
////////////////////

module lsu_tb;

    localparam int NUM_RECS    = 28;
    localparam int NUM_COLS    = 9;    // words per stimulus line
    localparam int C_STALL     = 0;
    localparam int C_OP        = 1;
    localparam int C_WIDTH     = 2;
    localparam int C_ADDR      = 3;
    localparam int C_DATA      = 4;
    localparam int C_RD        = 5;
    localparam int C_TAG       = 6;
    localparam int C_RES       = 7;
    localparam int C_LOAD      = 8;
    localparam int CREDIT_WAIT = 200;  // cycles allowed without an upstream credit
    localparam int DRAIN_WAIT  = 600;

    logic                      clk        = 1'b0;
    logic                      mem_resp_d = 1'b1;  // reset held from time 0
    logic                      in_valid   = 1'b0;
    rv32i_types_pkg::in_rec_t  in_rec     = '0;
    logic                      wb_credit  = 1'b0;
    logic                      in_credit;
    logic                      wb_valid;
    rv32i_types_pkg::wb_rec_t  wb_out;

    logic [31:0] stim [NUM_RECS*NUM_COLS];
    int          due [NUM_RECS];   // cycle at which each record's credit goes back
    int          cycle;
    int          sent;             // records pushed upstream
    int          credits_back;     // in_credit pulses seen
    int          rx_count;         // writeback records taken
    int          ret_count;        // wb_credit pulses given
    int          ret_delay;
    int          checks;
    int          mismatches;
    int          others;
    bit          timed_out;
    integer      seed = 32'h51901088;

    lsu_top lsu_top_i (
        .clk        (clk),
        .mem_resp_d (mem_resp_d),
        .in_valid   (in_valid),
        .in_rec     (in_rec),
        .in_credit  (in_credit),
        .wb_credit  (wb_credit),
        .wb_valid   (wb_valid),
        .wb_out     (wb_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] rec_word(input int r, input int col);
        return stim[r*NUM_COLS + col];
    endfunction

    function automatic rv32i_types_pkg::in_rec_t build_rec(input int r);
        rv32i_types_pkg::in_rec_t rec;
        logic [31:0]              w_op;
        logic [31:0]              w_width;
        logic [31:0]              w_rd;
        logic [31:0]              w_tag;
        w_op      = rec_word(r, C_OP);
        w_width   = rec_word(r, C_WIDTH);
        w_rd      = rec_word(r, C_RD);
        w_tag     = rec_word(r, C_TAG);
        rec.op    = rv32i_types_pkg::mem_op_e'(w_op[1:0]);
        rec.width = rv32i_types_pkg::width_e'(w_width[2:0]);
        rec.addr  = rec_word(r, C_ADDR);
        rec.data  = rec_word(r, C_DATA);  // store data or alu result
        rec.rd    = w_rd[4:0];
        rec.tag   = w_tag[7:0];
        return rec;
    endfunction

    task automatic check_field(input string name, input int r, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH %s record %0d: got %h expected %h", name, r, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at cycle %0d: %s", cycle, what);
        others++;
    endtask

    // mid-cycle monitor where outputs are settled
    always @(negedge clk) begin
        if (mem_resp_d === 1'b0) begin
            if (sent == 0) begin
                assert (!wb_valid) else report_error("wb_valid high before any record was sent");
                assert (!in_credit) else report_error("in_credit high before any record was sent");
            end
            if (in_credit) begin
                credits_back++;
            end
            assert (credits_back <= sent)
                else report_error("more input credits than records sent");
            if (wb_valid) begin
                assert (rx_count < NUM_RECS)
                    else report_error("writeback record beyond the end of the stimulus");
                if (rx_count < NUM_RECS) begin
                    check_field("wb_out.tag", rx_count, 32'(wb_out.tag),
                                rec_word(rx_count, C_TAG) & 32'hff);  // order check
                    check_field("wb_out.rd", rx_count, 32'(wb_out.rd),
                                rec_word(rx_count, C_RD) & 32'h1f);
                    check_field("wb_out.result", rx_count, wb_out.result,
                                rec_word(rx_count, C_RES));
                    check_field("wb_out.is_load", rx_count, 32'(wb_out.is_load),
                                rec_word(rx_count, C_LOAD));
                    ret_delay = $unsigned($random(seed)) % 4;
                    if (rec_word(rx_count, C_STALL) != 0) begin
                        ret_delay = ret_delay + 8;  // slow consumer
                    end
                    due[rx_count] = cycle + ret_delay;
                    rx_count++;
                end
            end
            assert (rx_count - ret_count <= lsu_flow_pkg::WB_CREDITS)
                else report_error("consumer holds more records than it has buffer slots");
        end
    end

    // consumer frees its slots in order with at most one credit pulse per cycle
    always @(posedge clk) begin
        #1;
        if (mem_resp_d === 1'b0 && ret_count < rx_count && due[ret_count] <= cycle) begin
            wb_credit = 1'b1;
            ret_count++;
        end else begin
            wb_credit = 1'b0;
        end
    end

    // upstream driver and end of run
    initial begin
        int wait_cyc;
        $readmemh("verification/lsu_stim.txt", stim);
        repeat (5) @(posedge clk);
        #1 mem_resp_d = 1'b0;
        repeat (4) @(posedge clk);  // quiet window after reset
        #1;
        wait_cyc = 0;
        while (sent < NUM_RECS && !timed_out) begin
            if (sent - credits_back < lsu_flow_pkg::IN_DEPTH) begin
                in_rec   = build_rec(sent);
                in_valid = 1'b1;
                sent++;
                wait_cyc = 0;
            end else begin
                in_valid = 1'b0;  // out of credits
                wait_cyc++;
                if (wait_cyc > CREDIT_WAIT) begin
                    report_error("timed out waiting for an upstream credit");
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        wait_cyc = 0;
        while (rx_count < NUM_RECS && !timed_out) begin
            @(posedge clk);
            wait_cyc++;
            if (wait_cyc > DRAIN_WAIT) begin
                report_error("timed out waiting for the remaining writeback records");
                timed_out = 1'b1;
            end
        end
        repeat (10) @(posedge clk);  // catches stray records or credits
        assert (credits_back == sent) else report_error("input credits not all returned");
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/rv32i_types_pkg.sv
source/lsu_flow_pkg.sv
source/lsu_queue.sv
source/mem_stage.sv
source/dmem_array.sv
source/wb_port.sv
source/lsu_top.sv
verification/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build the load/store testbench with Verilator and run it
# exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/lsu_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- verification/lsu_stim.txt
// stall op width addr data rd tag exp_result exp_is_load
// op 0 none 1 load 2 store, width is funct3, stall 1 slows the credit return
0 0 0 00000000 12345678 01 01 12345678 0
0 2 2 00000010 a1b2c3d4 00 02 a1b2c3d4 0
0 1 2 00000010 00000000 02 03 a1b2c3d4 1
0 2 0 00000021 000000ee 00 04 000000ee 0
0 2 1 00000022 00007788 00 05 00007788 0
1 1 2 00000020 00000000 03 06 7788ee00 1
1 2 0 00000020 00000055 00 07 00000055 0
1 1 2 00000020 00000000 04 08 7788ee55 1
1 0 0 00000000 cafef00d 05 09 cafef00d 0
0 2 1 0000000c 0000beef 00 0a 0000beef 0
0 1 2 0000000c 00000000 06 0b 0000beef 1
0 1 0 00000010 00000000 07 0c ffffffd4 1
0 1 0 00000011 00000000 08 0d ffffffc3 1
0 1 0 00000012 00000000 09 0e ffffffb2 1
0 1 0 00000013 00000000 0a 0f ffffffa1 1
0 1 4 00000010 00000000 0b 10 000000d4 1
0 1 4 00000011 00000000 0c 11 000000c3 1
0 1 4 00000012 00000000 0d 12 000000b2 1
1 1 4 00000013 00000000 0e 13 000000a1 1
1 1 1 00000010 00000000 0f 14 ffffc3d4 1
1 1 1 00000012 00000000 10 15 ffffa1b2 1
0 1 5 00000010 00000000 11 16 0000c3d4 1
0 1 5 00000012 00000000 12 17 0000a1b2 1
0 1 0 00000020 00000000 13 18 00000055 1
0 1 0 00000021 00000000 14 19 ffffffee 1
0 1 1 00000022 00000000 15 1a 00007788 1
0 0 0 00000004 00000042 16 1b 00000042 0
0 1 2 00000024 00000000 17 1c 00000000 1
